// File: compile.f
logic/core_pkg.sv
logic/hart_sched.sv
logic/hart_context.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/core_top.sv
bench/core_tb.sv

// File: Bender.yml
package:
  name: barrel_core

sources:
  - logic/core_pkg.sv
  - logic/hart_sched.sv
  - logic/hart_context.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/core_top.sv
  - target: test
    files:
      - bench/core_tb.sv

// File: bench/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    localparam int period    = 40;                        // Clock period in ns
    localparam int prog_len  = 8;                         // Words per hart program
    localparam int n_rows    = prog_len * core_pkg::num_harts;
    localparam int last_h    = core_pkg::num_harts - 1;   // Hart that gets stopped
    localparam int max_steps = 48;                        // Model bound for endless loops
    localparam int grace     = 3;                         // Retire delay of an in-flight slot
    localparam int wd_cycles = 4 + core_pkg::imem_depth + n_rows * core_pkg::num_harts + 200;

    typedef enum logic [3:0] {
        k_add, k_sub, k_and, k_or, k_xor, k_slt, k_addi, k_beq, k_bne, k_nop
    } kind_t;

    typedef struct packed {
        kind_t               kind;
        core_pkg::reg_addr_t rd;
        core_pkg::reg_addr_t rs1;
        core_pkg::reg_addr_t rs2;
        logic [12:0]         arg;                         // OR mask for addi imm or branch offset
    } row_t;

    typedef struct packed {
        core_pkg::reg_addr_t rd;
        core_pkg::word_t     data;
    } wb_t;

    ////////////////////////////////////////
    // Programs with one row per imem word
    ////////////////////////////////////////

    localparam core_pkg::word_t start_pc [core_pkg::num_harts] = '{32'h00, 32'h20, 32'h40, 32'h60};

    localparam row_t prog_tbl [n_rows] = '{
        // Hart 0 runs ALU ops on a negative and a random operand
        '{k_addi, 5'd1, 5'd0, 5'd0, 13'h000}, '{k_addi, 5'd2, 5'd0, 5'd0, 13'h800},
        '{k_add,  5'd3, 5'd1, 5'd2, 13'h000}, '{k_sub,  5'd4, 5'd1, 5'd2, 13'h000},
        '{k_and,  5'd5, 5'd1, 5'd2, 13'h000}, '{k_or,   5'd6, 5'd1, 5'd2, 13'h000},
        '{k_xor,  5'd7, 5'd1, 5'd2, 13'h000}, '{k_beq,  5'd0, 5'd0, 5'd0, 13'h000},
        // Hart 1 covers signed slt, x0 write and read and an unknown opcode
        '{k_addi, 5'd1, 5'd0, 5'd0, 13'h800}, '{k_sub,  5'd2, 5'd0, 5'd1, 13'h000},
        '{k_slt,  5'd3, 5'd1, 5'd2, 13'h000}, '{k_slt,  5'd4, 5'd2, 5'd1, 13'h000},
        '{k_addi, 5'd0, 5'd1, 5'd0, 13'h000}, '{k_add,  5'd5, 5'd0, 5'd2, 13'h000},
        '{k_nop,  5'd0, 5'd0, 5'd0, 13'h000}, '{k_beq,  5'd0, 5'd0, 5'd0, 13'h000},
        // Hart 2 has beq not taken, beq taken and bne not taken
        '{k_addi, 5'd1, 5'd0, 5'd0, 13'h001}, '{k_beq,  5'd0, 5'd1, 5'd0, 13'h008},
        '{k_add,  5'd2, 5'd1, 5'd0, 13'h000}, '{k_beq,  5'd0, 5'd1, 5'd2, 13'h008},
        '{k_addi, 5'd3, 5'd0, 5'd0, 13'h000}, '{k_bne,  5'd0, 5'd1, 5'd2, 13'h008},
        '{k_xor,  5'd4, 5'd1, 5'd2, 13'h000}, '{k_beq,  5'd0, 5'd0, 5'd0, 13'h000},
        // Hart 3 loops forever through a taken bne
        '{k_addi, 5'd1, 5'd0, 5'd0, 13'h000}, '{k_addi, 5'd2, 5'd0, 5'd0, 13'h001},
        '{k_add,  5'd1, 5'd1, 5'd2, 13'h000}, '{k_beq,  5'd0, 5'd1, 5'd0, 13'h008},
        '{k_xor,  5'd3, 5'd1, 5'd2, 13'h000}, '{k_bne,  5'd0, 5'd2, 5'd0, 13'h1ff4},
        '{k_addi, 5'd4, 5'd0, 5'd0, 13'h000}, '{k_beq,  5'd0, 5'd0, 5'd0, 13'h000}
    };

    logic                 clk;
    logic                 rst_n;
    logic                 prog_we;
    core_pkg::imem_addr_t prog_addr;
    core_pkg::word_t      prog_data;
    logic                 set_hart;
    logic                 set_hart_val;
    core_pkg::hart_id_t   set_hart_id;
    core_pkg::word_t      set_hart_pc;
    logic                 wb_en;
    core_pkg::hart_id_t   wb_hart;
    core_pkg::reg_addr_t  wb_rd;
    core_pkg::word_t      wb_data;

    logic [31:0] lfsr_state;                              // Immediate source
    logic [11:0] imm_tbl [n_rows];                        // Final addi immediates
    wb_t         exp_q [core_pkg::num_harts][$];          // Model writes per hart
    logic        hart_on [core_pkg::num_harts];           // Started and not stopped
    int          off_at [core_pkg::num_harts];            // Cycle of the last stop
    int          cyc;                                     // Rising edges since time 0
    int          last_hart;                               // Hart of previous write or -1
    int          last_cyc;

    core_top uut (
        .clk (clk), .rst_n (rst_n),
        .prog_we (prog_we), .prog_addr (prog_addr), .prog_data (prog_data),
        .set_hart (set_hart), .set_hart_id (set_hart_id),
        .set_hart_val (set_hart_val), .set_hart_pc (set_hart_pc),
        .wb_en (wb_en), .wb_hart (wb_hart), .wb_rd (wb_rd), .wb_data (wb_data)
    );

    always #(period / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_hart(input core_pkg::hart_id_t got, input core_pkg::hart_id_t exp,
                              input string what);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_rd(input core_pkg::reg_addr_t got, input core_pkg::reg_addr_t exp,
                            input string what);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s is x%0d, expected x%0d", $time, what, got, exp));
        end
    endtask

    task automatic check_word(input core_pkg::word_t got, input core_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    // Fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [11:0] draw_imm();
        logic [11:0] v;
        int          i;
        for (i = 0; i < 12; i++) begin
            lfsr_state = lfsr_next(lfsr_state);           // One step per bit
            v[i]       = lfsr_state[0];
        end
        return v;
    endfunction

    // Unknown opcode tagged with its word index
    function automatic core_pkg::word_t fill_word(input int a);
        return {6'(a), 19'd0, 7'h7f};
    endfunction

    function automatic core_pkg::word_t encode(input row_t r, input logic [11:0] imm);
        logic [12:0] o;
        logic [2:0]  f3;
        o  = r.arg;
        f3 = 3'b000;
        case (r.kind)
            k_addi: return {imm, r.rs1, 3'b000, r.rd, 7'b0010011};
            k_beq:  return {o[12], o[10:5], r.rs2, r.rs1, 3'b000, o[4:1], o[11], 7'b1100011};
            k_bne:  return {o[12], o[10:5], r.rs2, r.rs1, 3'b001, o[4:1], o[11], 7'b1100011};
            k_nop:  return {25'd0, 7'b0001111};           // Unimplemented FENCE
            k_slt:  f3 = 3'b010;
            k_xor:  f3 = 3'b100;
            k_or:   f3 = 3'b110;
            k_and:  f3 = 3'b111;
            default: f3 = 3'b000;                         // add, sub
        endcase
        return {(r.kind == k_sub) ? 7'b0100000 : 7'b0000000, r.rs2, r.rs1, f3, r.rd, 7'b0110011};
    endfunction

    ////////////////////////////////////////
    // ISA model that fills the expected queues
    ////////////////////////////////////////

    task automatic run_model(input int h);
        core_pkg::word_t regs [core_pkg::num_regs];
        core_pkg::word_t pc;
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t res;
        row_t            r;
        logic            taken;
        int              idx;
        int              step;
        for (idx = 0; idx < core_pkg::num_regs; idx++) regs[idx] = '0;
        pc = start_pc[h];
        for (step = 0; step < max_steps; step++) begin
            idx   = int'(pc >> 2);
            r     = prog_tbl[idx];
            a     = regs[r.rs1];                          // x0 stays zero
            b     = regs[r.rs2];
            res   = '0;
            taken = 1'b0;
            case (r.kind)
                k_add:  res = a + b;
                k_sub:  res = a - b;
                k_and:  res = a & b;
                k_or:   res = a | b;
                k_xor:  res = a ^ b;
                k_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                k_addi: res = a + {{20{imm_tbl[idx][11]}}, imm_tbl[idx]};
                k_beq:  taken = (a == b);
                k_bne:  taken = (a != b);
                default: ;
            endcase
            if (r.kind < k_beq && r.rd != '0) begin
                regs[r.rd] = res;
                exp_q[h].push_back('{rd: r.rd, data: res});
            end
            if (taken && r.arg == '0) break;              // Parked on a self loop
            pc = taken ? pc + {{19{r.arg[12]}}, r.arg} : pc + 32'd4;
        end
    endtask

    function automatic int pending();
        int n;
        int h;
        n = 0;
        for (h = 0; h < core_pkg::num_harts; h++) begin
            if (hart_on[h]) n += exp_q[h].size();
        end
        return n;
    endfunction

    task automatic take_write();
        wb_t want;
        int  h;
        h = int'(wb_hart);
        if (last_hart >= 0) begin                         // Round robin steps one hart per cycle
            check_hart(wb_hart, core_pkg::hart_id_t'((last_hart + cyc - last_cyc)
                       % core_pkg::num_harts), "write-back hart");
        end
        last_hart = h;
        last_cyc  = cyc;
        if (!hart_on[h] && cyc > off_at[h] + grace) begin
            fail_now($sformatf("hart %0d wrote x%0d at %0t while idle", h, wb_rd, $time));
        end
        if (exp_q[h].size() == 0) begin
            fail_now($sformatf("hart %0d wrote x%0d at %0t with no write left", h, wb_rd, $time));
        end
        want = exp_q[h].pop_front();
        check_rd(wb_rd, want.rd, "write-back rd");
        check_word(wb_data, want.data, "write-back data");
    endtask

    // Outputs settle after the rising edge
    always @(negedge clk) begin
        if (rst_n && wb_en) take_write();
    end

    initial begin
        #(wd_cycles * period);
        fail_now($sformatf("timeout with %0d expected writes still outstanding", pending()));
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        int a;
        int h;
        clk          = 1'b0;
        rst_n        = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        set_hart     = 1'b0;
        set_hart_val = 1'b0;
        set_hart_id  = '0;
        set_hart_pc  = '0;
        lfsr_state   = 32'h572d;
        cyc          = 0;
        last_hart    = -1;
        last_cyc     = 0;
        for (h = 0; h < core_pkg::num_harts; h++) begin
            hart_on[h] = 1'b0;
            off_at[h]  = -1000;                           // Never started
        end
        for (a = 0; a < n_rows; a++) imm_tbl[a] = draw_imm() | prog_tbl[a].arg[11:0];
        for (h = 0; h < core_pkg::num_harts; h++) run_model(h);
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        for (a = 0; a < core_pkg::imem_depth; a++) begin   // Load with all harts idle
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = core_pkg::imem_addr_t'(a);
            prog_data = (a < n_rows) ? encode(prog_tbl[a], imm_tbl[a]) : fill_word(a);
        end
        @(negedge clk);
        prog_we = 1'b0;
        repeat (2 * core_pkg::num_harts) @(negedge clk);
        for (h = 0; h < core_pkg::num_harts; h++) begin
            @(negedge clk);
            set_hart     = 1'b1;
            set_hart_val = 1'b1;
            set_hart_id  = core_pkg::hart_id_t'(h);
            set_hart_pc  = start_pc[h];
            hart_on[h]   = 1'b1;
        end
        @(negedge clk);
        set_hart = 1'b0;
        repeat (6 * core_pkg::num_harts) @(negedge clk);
        set_hart        = 1'b1;                           // Stop the looping hart
        set_hart_val    = 1'b0;
        set_hart_id     = core_pkg::hart_id_t'(last_h);
        hart_on[last_h] = 1'b0;
        off_at[last_h]  = cyc;
        @(negedge clk);
        set_hart = 1'b0;
        while (pending() != 0) @(negedge clk);
        repeat (3 * core_pkg::num_harts) @(negedge clk);  // No stray writes after the end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: logic/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                  clk,           // Clock
    input  logic                  rst_n,         // Async reset, active low
    input  logic                  prog_we,       // Imem load strobe
    input  core_pkg::imem_addr_t  prog_addr,
    input  core_pkg::word_t       prog_data,
    input  logic                  set_hart,      // Hart start/stop
    input  core_pkg::hart_id_t    set_hart_id,
    input  logic                  set_hart_val,
    input  core_pkg::word_t       set_hart_pc,
    output logic                  wb_en,         // Write-back observation
    output core_pkg::hart_id_t    wb_hart,
    output core_pkg::reg_addr_t   wb_rd,
    output core_pkg::word_t       wb_data
);

    logic                issue_valid;            // Scheduler to IF
    core_pkg::hart_id_t  issue_hid;
    core_pkg::word_t     hart_pc  [core_pkg::num_harts]; // Contexts to IF
    core_pkg::word_t     rs1_data [core_pkg::num_harts]; // Contexts to ID
    core_pkg::word_t     rs2_data [core_pkg::num_harts];
    core_pkg::reg_addr_t rs1_addr;               // ID to contexts
    core_pkg::reg_addr_t rs2_addr;
    logic                f_valid;                // IF/ID
    core_pkg::hart_id_t  f_hart;
    core_pkg::word_t     f_pc;
    core_pkg::word_t     f_insn;
    logic                d_valid;                // ID/EX
    core_pkg::hart_id_t  d_hart;
    core_pkg::word_t     d_pc;
    core_pkg::alu_op_t   d_alu_op;
    core_pkg::word_t     d_op_a;
    core_pkg::word_t     d_op_b;
    core_pkg::reg_addr_t d_rd;
    logic                d_we;
    logic                d_is_branch;
    logic                d_br_ne;
    core_pkg::word_t     d_br_target;
    logic                pc_we;                  // EX to contexts
    core_pkg::word_t     pc_next;

    hart_sched u_sched (
        .clk (clk), .rst_n (rst_n),
        .set_hart (set_hart), .set_hart_val (set_hart_val), .set_hart_id (set_hart_id),
        .issue_valid (issue_valid), .issue_hid (issue_hid)
    );

    ////////////////////////////////////////
    // Per-hart PC and GPR file
    ////////////////////////////////////////

    for (genvar g = 0; g < core_pkg::num_harts; g++) begin : g_hart
        hart_context #(.HART_ID(g)) u_ctx (
            .clk (clk), .rst_n (rst_n),
            .set_hart (set_hart), .set_hart_val (set_hart_val),
            .set_hart_id (set_hart_id), .set_hart_pc (set_hart_pc),
            .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
            .ex_hart (wb_hart), .pc_we (pc_we), .pc_next (pc_next), // Broadcast from EX
            .wb_en (wb_en), .wb_rd (wb_rd), .wb_data (wb_data),
            .pc (hart_pc[g]), .rs1_data (rs1_data[g]), .rs2_data (rs2_data[g])
        );
    end

    fetch_stage u_fetch (
        .clk (clk), .rst_n (rst_n),
        .prog_we (prog_we), .prog_addr (prog_addr), .prog_data (prog_data),
        .issue_valid (issue_valid), .issue_hid (issue_hid), .hart_pc (hart_pc),
        .f_valid (f_valid), .f_hart (f_hart), .f_pc (f_pc), .f_insn (f_insn)
    );

    decode_stage u_decode (
        .clk (clk), .rst_n (rst_n),
        .f_valid (f_valid), .f_hart (f_hart), .f_pc (f_pc), .f_insn (f_insn),
        .hart_rs1_data (rs1_data), .hart_rs2_data (rs2_data),
        .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
        .d_valid (d_valid), .d_hart (d_hart), .d_pc (d_pc), .d_alu_op (d_alu_op),
        .d_op_a (d_op_a), .d_op_b (d_op_b), .d_rd (d_rd), .d_we (d_we),
        .d_is_branch (d_is_branch), .d_br_ne (d_br_ne), .d_br_target (d_br_target)
    );

    execute_stage u_execute (
        .clk (clk), .rst_n (rst_n),
        .d_valid (d_valid), .d_hart (d_hart), .d_pc (d_pc), .d_alu_op (d_alu_op),
        .d_op_a (d_op_a), .d_op_b (d_op_b), .d_rd (d_rd), .d_we (d_we),
        .d_is_branch (d_is_branch), .d_br_ne (d_br_ne), .d_br_target (d_br_target),
        .wb_en (wb_en), .ex_hart (wb_hart), .wb_rd (wb_rd), .wb_data (wb_data), // Test port
        .pc_we (pc_we), .pc_next (pc_next)
    );

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                 clk,            // Clock
    input  logic                 rst_n,          // Async reset, active low
    input  logic                 d_valid,        // ID/EX valid
    input  core_pkg::hart_id_t   d_hart,
    input  core_pkg::word_t      d_pc,
    input  core_pkg::alu_op_t    d_alu_op,
    input  core_pkg::word_t      d_op_a,
    input  core_pkg::word_t      d_op_b,
    input  core_pkg::reg_addr_t  d_rd,
    input  logic                 d_we,
    input  logic                 d_is_branch,
    input  logic                 d_br_ne,
    input  core_pkg::word_t      d_br_target,
    output logic                 wb_en,          // GPR write strobe
    output core_pkg::hart_id_t   ex_hart,        // Retiring hart
    output core_pkg::reg_addr_t  wb_rd,
    output core_pkg::word_t      wb_data,
    output logic                 pc_we,          // PC update strobe
    output core_pkg::word_t      pc_next
);

    core_pkg::word_t alu_out;
    logic            br_taken;

    always_comb begin
        case (d_alu_op)
            core_pkg::alu_sub: alu_out = d_op_a - d_op_b;
            core_pkg::alu_and: alu_out = d_op_a & d_op_b;
            core_pkg::alu_or:  alu_out = d_op_a | d_op_b;
            core_pkg::alu_xor: alu_out = d_op_a ^ d_op_b;
            core_pkg::alu_slt: alu_out = {31'd0, $signed(d_op_a) < $signed(d_op_b)};
            default:           alu_out = d_op_a + d_op_b; // add, addi
        endcase
    end

    // Equality, inverted for bne
    assign br_taken = d_is_branch && ((d_op_a == d_op_b) != d_br_ne);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
            pc_we <= 1'b0;
        end else begin
            wb_en <= d_valid && d_we;
            pc_we <= d_valid;                    // Every retire moves the PC
        end
    end

    always_ff @(posedge clk) begin
        ex_hart <= d_hart;
        wb_rd   <= d_rd;
        wb_data <= alu_out;
        pc_next <= br_taken ? d_br_target : d_pc + 32'd4;
    end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                 clk,            // Clock
    input  logic                 rst_n,          // Async reset, active low
    input  logic                 f_valid,        // IF/ID valid
    input  core_pkg::hart_id_t   f_hart,         // IF/ID hart
    input  core_pkg::word_t      f_pc,           // IF/ID PC
    input  core_pkg::word_t      f_insn,         // IF/ID instruction
    input  core_pkg::word_t      hart_rs1_data [core_pkg::num_harts], // Read data 0, all harts
    input  core_pkg::word_t      hart_rs2_data [core_pkg::num_harts], // Read data 1, all harts
    output core_pkg::reg_addr_t  rs1_addr,       // To every context
    output core_pkg::reg_addr_t  rs2_addr,
    output logic                 d_valid,        // ID/EX valid
    output core_pkg::hart_id_t   d_hart,
    output core_pkg::word_t      d_pc,
    output core_pkg::alu_op_t    d_alu_op,
    output core_pkg::word_t      d_op_a,         // ALU input 0
    output core_pkg::word_t      d_op_b,         // ALU input 1 or branch compare
    output core_pkg::reg_addr_t  d_rd,
    output logic                 d_we,           // Writes a nonzero rd
    output logic                 d_is_branch,
    output logic                 d_br_ne,        // 1 bne, 0 beq
    output core_pkg::word_t      d_br_target
);

    core_pkg::opcode_t   opcode;
    logic [2:0]          funct3;
    core_pkg::reg_addr_t rd;
    core_pkg::word_t     imm_i;                  // I-type, sign extended
    core_pkg::word_t     imm_b;                  // B-type, sign extended
    core_pkg::alu_op_t   alu_op;
    logic                we;
    logic                is_branch;
    logic                use_imm;

    assign opcode   = core_pkg::opcode_t'(f_insn[6:0]);
    assign funct3   = f_insn[14:12];
    assign rd       = f_insn[11:7];
    assign rs1_addr = f_insn[19:15];
    assign rs2_addr = f_insn[24:20];
    assign imm_i    = {{20{f_insn[31]}}, f_insn[31:20]};
    assign imm_b    = {{19{f_insn[31]}}, f_insn[31], f_insn[7], f_insn[30:25], f_insn[11:8], 1'b0};

    ////////////////////////////////////////
    // Opcode and funct decode
    ////////////////////////////////////////

    always_comb begin
        alu_op    = core_pkg::alu_add;
        we        = 1'b0;
        is_branch = 1'b0;
        use_imm   = 1'b0;
        case (opcode)
            core_pkg::opc_op: begin
                we = 1'b1;
                case (funct3)
                    3'b000:  alu_op = f_insn[30] ? core_pkg::alu_sub : core_pkg::alu_add;
                    3'b010:  alu_op = core_pkg::alu_slt;
                    3'b100:  alu_op = core_pkg::alu_xor;
                    3'b110:  alu_op = core_pkg::alu_or;
                    3'b111:  alu_op = core_pkg::alu_and;
                    default: we = 1'b0;                  // Shifts etc. retire as nop
                endcase
            end
            core_pkg::opc_op_imm: begin
                use_imm = 1'b1;
                we      = (funct3 == 3'b000);           // addi only
            end
            core_pkg::opc_branch: is_branch = (funct3[2:1] == 2'b00); // beq, bne
            default: ;                                   // Unknown, nop
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid     <= 1'b0;
            d_we        <= 1'b0;
            d_is_branch <= 1'b0;
        end else begin
            d_valid     <= f_valid;
            d_we        <= f_valid && we && (rd != '0); // x0 never written
            d_is_branch <= f_valid && is_branch;
        end
    end

    always_ff @(posedge clk) begin
        d_hart      <= f_hart;
        d_pc        <= f_pc;
        d_alu_op    <= alu_op;
        d_op_a      <= hart_rs1_data[f_hart];           // Own hart's operands
        d_op_b      <= use_imm ? imm_i : hart_rs2_data[f_hart];
        d_rd        <= rd;
        d_br_ne     <= funct3[0];
        d_br_target <= f_pc + imm_b;                    // PC relative
    end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                  clk,          // Clock
    input  logic                  rst_n,        // Async reset, active low
    input  logic                  prog_we,      // Program load strobe
    input  core_pkg::imem_addr_t  prog_addr,    // Load word index
    input  core_pkg::word_t       prog_data,    // Load word
    input  logic                  issue_valid,  // Slot is live
    input  core_pkg::hart_id_t    issue_hid,    // Slot owner
    input  core_pkg::word_t       hart_pc [core_pkg::num_harts], // PC of every hart
    output logic                  f_valid,      // IF/ID valid
    output core_pkg::hart_id_t    f_hart,       // IF/ID hart
    output core_pkg::word_t       f_pc,         // IF/ID PC
    output core_pkg::word_t       f_insn        // IF/ID instruction
);

    core_pkg::word_t      imem [core_pkg::imem_depth]; // Shared by all harts
    core_pkg::word_t      sel_pc;                      // PC of issued hart
    core_pkg::imem_addr_t rd_addr;                     // Word index of sel_pc

    // Load port, one word per cycle
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    assign sel_pc  = hart_pc[issue_hid];
    assign rd_addr = sel_pc[2 +: $bits(core_pkg::imem_addr_t)]; // Drop byte offset

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            f_valid <= 1'b0;
        end else begin
            f_valid <= issue_valid;              // Bubble stays a bubble
        end
    end

    always_ff @(posedge clk) begin
        f_hart <= issue_hid;
        f_pc   <= sel_pc;
        f_insn <= imem[rd_addr];                 // Async read, registered here
    end

endmodule

// File: logic/hart_context.sv
`timescale 1ns/1ps

module hart_context #(
    parameter int HART_ID = 0                    // Index of this hart
) (
    input  logic                 clk,            // Clock
    input  logic                 rst_n,          // Async reset, active low
    input  logic                 set_hart,       // Start/stop strobe
    input  logic                 set_hart_val,   // 1 start
    input  core_pkg::hart_id_t   set_hart_id,    // Addressed hart
    input  core_pkg::word_t      set_hart_pc,    // Start address
    input  core_pkg::reg_addr_t  rs1_addr,       // Read address 0
    input  core_pkg::reg_addr_t  rs2_addr,       // Read address 1
    input  core_pkg::hart_id_t   ex_hart,        // Hart retiring in EX
    input  logic                 pc_we,          // PC update strobe
    input  core_pkg::word_t      pc_next,        // New PC
    input  logic                 wb_en,          // GPR write enable
    input  core_pkg::reg_addr_t  wb_rd,          // GPR write address
    input  core_pkg::word_t      wb_data,        // GPR write data
    output core_pkg::word_t      pc,             // PC seen by fetch
    output core_pkg::word_t      rs1_data,       // Read data 0
    output core_pkg::word_t      rs2_data        // Read data 1
);

    core_pkg::word_t regs [core_pkg::num_regs];  // GPR file, x0 never read
    core_pkg::word_t pc_q;
    logic            own_start;                  // Start addressed here
    logic            own_ex;                     // EX result belongs to this hart

    assign own_start = set_hart && set_hart_val && (set_hart_id == core_pkg::hart_id_t'(HART_ID));
    assign own_ex    = (ex_hart == core_pkg::hart_id_t'(HART_ID));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (own_start) begin
            pc_q <= set_hart_pc;                 // Start wins over retire
        end else if (pc_we && own_ex) begin
            pc_q <= pc_next;
        end
    end

    // Bypass lets a slot right after retire see the new PC
    assign pc = (pc_we && own_ex) ? pc_next : pc_q;

    always_ff @(posedge clk) begin
        if (wb_en && own_ex && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr]; // x0 reads zero
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: logic/hart_sched.sv
`timescale 1ns/1ps

module hart_sched (
    input  logic                 clk,          // Clock
    input  logic                 rst_n,        // Async reset, active low
    input  logic                 set_hart,     // Start/stop strobe
    input  logic                 set_hart_val, // 1 start, 0 idle
    input  core_pkg::hart_id_t   set_hart_id,  // Hart addressed by strobe
    output logic                 issue_valid,  // Slot carries an instruction
    output core_pkg::hart_id_t   issue_hid     // Hart owning this slot
);

    logic [core_pkg::num_harts-1:0] active_q;   // One bit per running hart
    logic [core_pkg::num_harts-1:0] active_nxt; // Bitmap incl. this cycle's strobe
    core_pkg::hart_id_t             next_slot;  // Slot after the current one

    // Strobe is folded in so it counts for the very next slot
    always_comb begin
        active_nxt = active_q;
        if (set_hart) begin
            active_nxt[set_hart_id] = set_hart_val;
        end
    end

    assign next_slot = (issue_hid == core_pkg::hart_id_t'(core_pkg::num_harts - 1))
                     ? '0 : issue_hid + 1'b1;   // Wrap at last hart

    // issue_hid doubles as the slot counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q    <= '0;                  // All harts idle
            issue_hid   <= '0;
            issue_valid <= 1'b0;
        end else begin
            active_q    <= active_nxt;
            issue_hid   <= next_slot;           // Fixed round robin
            issue_valid <= active_nxt[next_slot]; // Idle slot is a bubble
        end
    end

endmodule

// File: logic/core_pkg.sv
package core_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int xlen       = 32;            // Data word width
    localparam int num_harts  = 4;             // At least 3, one per pipeline stage
    localparam int num_regs   = 32;            // GPRs per hart, x0 hardwired
    localparam int imem_depth = 64;            // Instruction memory words

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [xlen-1:0]                word_t;      // Data or instruction word
    typedef logic [$clog2(num_regs)-1:0]    reg_addr_t;  // Register index
    typedef logic [$clog2(num_harts)-1:0]   hart_id_t;   // Hart index
    typedef logic [$clog2(imem_depth)-1:0]  imem_addr_t; // Word index into imem

    // RV32I major opcodes kept by this core
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,               // Register-register
        opc_op_imm = 7'b0010011,               // Register-immediate
        opc_branch = 7'b1100011                // Conditional branch
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5                         // Signed compare
    } alu_op_t;

endpackage
